//--- design/pktgen_cfg.svh
`ifndef PKTGEN_CFG_SVH
`define PKTGEN_CFG_SVH

// Image RAM depth in instruction words
`define PKTGEN_TCM_WORDS 16

`define PKTGEN_CMD_PROBE 16'h9001
`define PKTGEN_CMD_TCM_WR 16'h9003
`define PKTGEN_CMD_READ 16'h9002
`define PKTGEN_CMD_STATUS 16'h9004

// Arguments of the two status reads
`define PKTGEN_STATUS_ARG_A 128
`define PKTGEN_STATUS_ARG_B 129

`endif

//--- design/pktgen_pkg.sv
`default_nettype none

`include "pktgen_cfg.svh"

package pktgen_pkg;

	typedef logic [133:0] flit_t;
	typedef logic [127:0] payload_t;
	typedef logic [1:0] flit_kind_t;

	// Flit type field, top two bits of a flit
	localparam flit_kind_t KIND_HEAD = 2'b01;
	localparam flit_kind_t KIND_BODY = 2'b11;
	localparam flit_kind_t KIND_TAIL = 2'b10;

	typedef logic [31:0] instr_word_t;
	typedef logic [31:0] tcm_addr_t;
	typedef logic [$clog2(`PKTGEN_TCM_WORDS)-1:0] img_index_t;

	// Packets in the order they go out
	typedef enum logic [2:0] {
		PKT_PROBE,
		PKT_TCM,
		PKT_READ,
		PKT_STAT_A,
		PKT_STAT_B,
		PKT_SELECT
	} pkt_id_t;

	typedef enum logic [2:0] {ST_IDLE, ST_HEAD, ST_CMD, ST_STREAM, ST_DONE} seq_state_t;

endpackage

`default_nettype wire

//--- design/cmd_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cmd_link_if import pktgen_pkg::*; ();

	logic take;
	pkt_id_t pkt;
	payload_t payload;
	logic last;

	modport seq (
		output take,
		output pkt,
		input payload,
		input last
	);

	modport gen (
		input take,
		input pkt,
		output payload,
		output last
	);

endinterface

`default_nettype wire

//--- design/cmd_packet_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_cfg.svh"

module cmd_packet_gen import pktgen_pkg::*; (
	input logic clk,
	input logic resetn,
	cmd_link_if.gen cmd
);

	// Index of the final body in the command portion
	localparam logic [2:0] LAST_SHORT = 3'd1;
	localparam logic [2:0] LAST_FULL = 3'd5;

	logic [2:0] cnt;
	logic [2:0] last_idx;
	logic [7:0] cnt_arg;

	// Argument in the upper 112 bits
	function automatic payload_t arg_hi(input logic [7:0] v);
		return {104'd0, v, 16'd0};
	endfunction

	function automatic payload_t arg_lo(input logic [7:0] v);
		return {120'd0, v};
	endfunction

	function automatic logic [15:0] cmd_code(input pkt_id_t p);
		case (p)
			PKT_TCM: return `PKTGEN_CMD_TCM_WR;
			PKT_READ: return `PKTGEN_CMD_READ;
			PKT_STAT_A, PKT_STAT_B: return `PKTGEN_CMD_STATUS;
			default: return `PKTGEN_CMD_PROBE;
		endcase
	endfunction

	assign last_idx = (cmd.pkt == PKT_TCM) ? LAST_SHORT : LAST_FULL;
	assign cmd.last = (cnt == last_idx);
	assign cnt_arg = 8'(cnt) - 8'd1;

	always_comb begin
		cmd.payload = '0;
		if (cnt == 3'd1) begin
			cmd.payload = {96'd0, cmd_code(cmd.pkt), 16'd0};
		end else if (cnt >= 3'd2) begin
			case (cmd.pkt)
				PKT_PROBE: cmd.payload = arg_hi(cnt_arg);
				PKT_READ: cmd.payload = arg_lo(cnt_arg);
				PKT_STAT_A: cmd.payload = (cnt == 3'd2) ?
					arg_hi(8'(`PKTGEN_STATUS_ARG_A)) : arg_lo(cnt_arg);
				PKT_STAT_B: cmd.payload = (cnt == 3'd2) ?
					arg_hi(8'(`PKTGEN_STATUS_ARG_B)) : arg_lo(cnt_arg);
				// Select counts its arguments from zero
				PKT_SELECT: cmd.payload = arg_lo(cnt_arg - 8'd1);
				default: cmd.payload = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (cmd.take) begin
			cnt <= cmd.last ? 3'd0 : cnt + 3'd1;
		end
	end

	// Counter never runs past the current packet's command portion
	a_cnt_in_range: assert property (@(posedge clk) disable iff (!resetn)
		cnt <= last_idx);

endmodule

`default_nettype wire

//--- design/tcm_image_streamer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_cfg.svh"

module tcm_image_streamer import pktgen_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic img_we,
	input img_index_t img_addr,
	input instr_word_t img_data,
	input logic stream_take,
	output payload_t stream_payload,
	output logic stream_last
);

	localparam img_index_t LAST_IDX = img_index_t'(`PKTGEN_TCM_WORDS - 1);

	instr_word_t mem [`PKTGEN_TCM_WORDS];
	img_index_t idx;
	tcm_addr_t word_addr;

	// Image load port
	always_ff @(posedge clk) begin
		if (img_we) begin
			mem[img_addr] <= img_data;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			idx <= '0;
		end else if (stream_take) begin
			idx <= stream_last ? '0 : idx + 1'b1;
		end
	end

	// Word index doubles as the TCM address
	assign word_addr = tcm_addr_t'(idx);
	assign stream_last = (idx == LAST_IDX);
	assign stream_payload = {48'd0, mem[idx], word_addr, 16'd0};

	a_img_addr_range: assert property (@(posedge clk) disable iff (!resetn)
		img_we |-> (32'(img_addr) < `PKTGEN_TCM_WORDS));

endmodule

`default_nettype wire

//--- design/packet_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_sequencer import pktgen_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start,
	cmd_link_if.seq cmd,
	output logic stream_take,
	input payload_t stream_payload,
	input logic stream_last,
	output logic flit_valid,
	output flit_t flit
);

	seq_state_t state;
	pkt_id_t pkt;
	pkt_id_t pkt_next;
	logic emit;
	flit_kind_t kind;
	payload_t body;

	assign cmd.pkt = pkt;
	assign cmd.take = (state == ST_CMD);
	assign stream_take = (state == ST_STREAM);
	assign pkt_next = pkt_id_t'(pkt + 3'd1);

	// A flit is loaded on every cycle of a run
	assign emit = ((state == ST_IDLE) && start) || (state == ST_HEAD) ||
		(state == ST_CMD) || (state == ST_STREAM);

	always_comb begin
		kind = KIND_HEAD;
		body = '0;
		case (state)
			ST_CMD: begin
				// Load packet ends in the stream, not the command portion
				kind = (cmd.last && (pkt != PKT_TCM)) ? KIND_TAIL : KIND_BODY;
				body = cmd.payload;
			end
			ST_STREAM: begin
				kind = stream_last ? KIND_TAIL : KIND_BODY;
				body = stream_payload;
			end
			default: begin
				kind = KIND_HEAD;
				body = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			flit <= {kind, 4'b0, body};
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= ST_IDLE;
			pkt <= PKT_PROBE;
			flit_valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_CMD;
						pkt <= PKT_PROBE;
						flit_valid <= 1'b1;
					end
				end
				ST_HEAD: state <= ST_CMD;
				ST_CMD: begin
					if (cmd.last) begin
						if (pkt == PKT_TCM) begin
							state <= ST_STREAM;
						end else if (pkt == PKT_SELECT) begin
							state <= ST_DONE;
						end else begin
							state <= ST_HEAD;
							pkt <= pkt_next;
						end
					end
				end
				ST_STREAM: begin
					if (stream_last) begin
						state <= ST_HEAD;
						pkt <= pkt_next;
					end
				end
				default: begin
					flit_valid <= 1'b0;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Only the load packet hands its bodies to the streamer
	a_one_source: assert property (@(posedge clk) disable iff (!resetn)
		stream_take |-> (pkt == PKT_TCM) && !cmd.take);

	// A run only begins on a sampled start
	a_valid_on_start: assert property (@(posedge clk) disable iff (!resetn)
		$rose(flit_valid) |-> $past(start));

endmodule

`default_nettype wire

//--- design/tcm_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_cfg.svh"

module tcm_loader_top import pktgen_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start,
	input logic img_we,
	input logic [$clog2(`PKTGEN_TCM_WORDS)-1:0] img_addr,
	input logic [31:0] img_data,
	output logic flit_valid,
	output logic [133:0] flit
);

	logic stream_take;
	payload_t stream_payload;
	logic stream_last;

	cmd_link_if cmd ();

	packet_sequencer u_seq (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.cmd(cmd.seq),
		.stream_take(stream_take),
		.stream_payload(stream_payload),
		.stream_last(stream_last),
		.flit_valid(flit_valid),
		.flit(flit)
	);

	cmd_packet_gen u_cmd (
		.clk(clk),
		.resetn(resetn),
		.cmd(cmd.gen)
	);

	tcm_image_streamer u_img (
		.clk(clk),
		.resetn(resetn),
		.img_we(img_we),
		.img_addr(img_addr),
		.img_data(img_data),
		.stream_take(stream_take),
		.stream_payload(stream_payload),
		.stream_last(stream_last)
	);

endmodule

`default_nettype wire

//--- sim/tb_tcm_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pktgen_cfg.svh"

module tb_tcm_loader;

	localparam int DEPTH = `PKTGEN_TCM_WORDS;
	localparam int AW = $clog2(DEPTH);

	logic clk;
	logic resetn;
	logic start;
	logic img_we;
	logic [AW-1:0] img_addr;
	logic [31:0] img_data;
	logic flit_valid;
	logic [133:0] flit;

	logic [31:0] cases [0:63];
	logic [31:0] image [DEPTH];
	logic [127:0] body_q [$];
	logic [133:0] exp_q [$];
	int timeout_cycles;

	tcm_loader_top dut (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.img_we(img_we),
		.img_addr(img_addr),
		.img_data(img_data),
		.flit_valid(flit_valid),
		.flit(flit)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic expect_level(input string name, input logic exp, input logic got);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, name, exp, got);
			abort_run("output level mismatch");
		end
	endtask

	task automatic expect_flit(input int idx, input logic [133:0] exp, input logic [133:0] got);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: flit[%0d] expected %h got %h", $time, idx, exp, got);
			abort_run("flit content mismatch");
		end
	endtask

	// Argument in bits 127:16
	function automatic logic [127:0] upper_arg(input int v);
		logic [127:0] p;
		p = '0;
		p[127:16] = 112'(v);
		return p;
	endfunction

	function automatic logic [127:0] lower_arg(input int v);
		return 128'(v);
	endfunction

	function automatic logic [127:0] cmd_word(input logic [15:0] code);
		logic [127:0] p;
		p = '0;
		p[31:16] = code;
		return p;
	endfunction

	function automatic logic [127:0] load_word(input int idx, input logic [31:0] w);
		logic [127:0] p;
		p = '0;
		p[79:48] = w;
		p[47:16] = 32'(idx);
		return p;
	endfunction

	// Head, then the queued bodies with the final one marked tail
	task automatic close_packet();
		exp_q.push_back({2'b01, 4'b0, 128'd0});
		foreach (body_q[i]) begin
			exp_q.push_back({(i == body_q.size() - 1) ? 2'b10 : 2'b11, 4'b0, body_q[i]});
		end
		body_q.delete();
	endtask

	task automatic build_expected();
		exp_q.delete();
		body_q.push_back('0);
		body_q.push_back(cmd_word(`PKTGEN_CMD_PROBE));
		for (int a = 1; a <= 4; a++) begin
			body_q.push_back(upper_arg(a));
		end
		close_packet();
		body_q.push_back('0);
		body_q.push_back(cmd_word(`PKTGEN_CMD_TCM_WR));
		for (int i = 0; i < DEPTH; i++) begin
			body_q.push_back(load_word(i, image[i]));
		end
		close_packet();
		body_q.push_back('0);
		body_q.push_back(cmd_word(`PKTGEN_CMD_READ));
		for (int a = 1; a <= 4; a++) begin
			body_q.push_back(lower_arg(a));
		end
		close_packet();
		for (int s = 0; s < 2; s++) begin
			body_q.push_back('0);
			body_q.push_back(cmd_word(`PKTGEN_CMD_STATUS));
			body_q.push_back(upper_arg((s == 0) ? `PKTGEN_STATUS_ARG_A : `PKTGEN_STATUS_ARG_B));
			for (int a = 2; a <= 4; a++) begin
				body_q.push_back(lower_arg(a));
			end
			close_packet();
		end
		body_q.push_back('0);
		body_q.push_back(cmd_word(`PKTGEN_CMD_PROBE));
		for (int a = 0; a <= 3; a++) begin
			body_q.push_back(lower_arg(a));
		end
		close_packet();
	endtask

	task automatic write_image(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			img_we = 1'b1;
			img_addr = AW'(i);
			img_data = image[i];
		end
		@(posedge clk);
		#1;
		img_we = 1'b0;
	endtask

	// busy_at is the flit number after which a second start is pulsed
	task automatic run_once(input int busy_at);
		build_expected();
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		for (int n = 0; n < exp_q.size(); n++) begin
			@(negedge clk);
			expect_level("flit_valid", 1'b1, flit_valid);
			expect_flit(n, exp_q[n], flit);
			@(posedge clk);
			#1;
			start = (busy_at != 0) && (n + 1 == busy_at);
		end
		repeat (4) begin
			@(negedge clk);
			expect_level("flit_valid", 1'b0, flit_valid);
		end
	endtask

	initial begin
		int runs;
		int base;
		int reload;
		int count;
		int busy_at;
		clk = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		img_we = 1'b0;
		img_addr = '0;
		img_data = '0;
		timeout_cycles = 0;
		void'($urandom(32'hfa16_0465));
		$readmemh("sim/loader_cases.txt", cases);
		if ($isunknown(cases[0]) || cases[0] == 0) begin
			abort_run("case file holds no runs");
		end
		runs = cases[0];
		timeout_cycles = (runs + 2) * (60 + DEPTH) + 64;
		base = 1 + 3 * runs;
		for (int i = 0; i < DEPTH; i++) begin
			image[i] = cases[base + i];
		end
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;
		repeat (3) begin
			@(negedge clk);
			expect_level("flit_valid", 1'b0, flit_valid);
		end
		write_image(DEPTH);
		for (int r = 0; r < runs; r++) begin
			reload = cases[1 + 3 * r];
			count = cases[2 + 3 * r];
			busy_at = cases[3 + 3 * r];
			if (count != DEPTH) begin
				abort_run("word count in case file does not match the image depth");
			end
			if (busy_at >= 38 + DEPTH) begin
				abort_run("busy start cycle in case file lies outside the run");
			end
			if (reload != 0) begin
				for (int i = 0; i < count; i++) begin
					image[i] = $urandom();
				end
				write_image(count);
			end
			run_once(busy_at);
		end
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		abort_run("timeout, the runs did not finish within the cycle budget");
	end

endmodule

`default_nettype wire

//--- sim/loader_cases.txt
// Line 1 is the run count. Each run line holds reload flag, word count, busy start cycle (0 none)
// After the runs comes the initial image, one 32-bit word per line in index order
4
0 10 00
0 10 14
1 10 35
1 10 00
00000013
00a00093
01400113
002081b3
40110233
0041a2b3
00520333
0062f3b3
00731463
00138393
fe5ff06f
deadbeef
0a5a5a5a
13572468
fedcba98
80000001

//--- project.f
+incdir+design
design/pktgen_pkg.sv
design/cmd_link_if.sv
design/cmd_packet_gen.sv
design/tcm_image_streamer.sv
design/packet_sequencer.sv
design/tcm_loader_top.sv
sim/tb_tcm_loader.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_tcm_loader
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= PASS: all tests
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
